//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module rename_tb -Mdir obj_dir
	./obj_dir/Vrename_tb | awk '{ print } index($$0, "** PASS **") { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- design/multiport_fifo.sv
module multiport_fifo #(
    parameter type dtype     = logic,
    parameter int  IN_W      = 4,
    parameter int  OUT_W     = 2,
    parameter int  DEPTH     = 16,
    parameter int  INIT_FULL = 0
) (
    input  logic             clk,
    input  logic             i_arst_n,
    input  logic             i_flush,
    // enqueue side
    output logic             o_can_enq,
    input  logic             i_enq_vld,
    input  logic [IN_W-1:0]  i_enq_req,
    input  dtype             i_enq_data [IN_W],
    // dequeue side
    output logic [OUT_W-1:0] o_can_deq,
    input  logic [OUT_W-1:0] i_deq_req,
    output dtype             o_deq_data [OUT_W],
    input  dtype             i_init_data [DEPTH]
);

    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [CW-1:0] COUNT_INIT = (INIT_FULL != 0) ? CW'(DEPTH) : '0;

    dtype buffer [DEPTH];

    logic [PW-1:0]    enq_ptr [IN_W];
    logic [PW-1:0]    deq_ptr [OUT_W];
    logic [CW-1:0]    count;

    logic [IN_W-1:0]  enq_fire;
    logic [OUT_W-1:0] deq_fire;
    logic [CW-1:0]    enq_num;
    logic [CW-1:0]    enq_fire_num;
    logic [CW-1:0]    deq_num;
    logic [CW-1:0]    remaining;

    // pointer step with wrap at DEPTH
    function automatic logic [PW-1:0] advance(
        input logic [PW-1:0] ptr,
        input logic [CW-1:0] step
    );
        logic [CW:0] sum;
        sum = (CW+1)'(ptr) + (CW+1)'(step);
        if (sum >= (CW+1)'(DEPTH)) begin
            sum = sum - (CW+1)'(DEPTH);
        end
        return PW'(sum);
    endfunction

    assign enq_num      = CW'(rename_pkg::popcount(rename_pkg::POP_W'(i_enq_req)));
    assign remaining    = CW'(DEPTH) - count;
    // all or nothing
    assign o_can_enq    = enq_num <= remaining;
    assign enq_fire     = (i_enq_vld && o_can_enq) ? i_enq_req : '0;
    assign deq_fire     = i_deq_req & o_can_deq;
    assign enq_fire_num = CW'(rename_pkg::popcount(rename_pkg::POP_W'(enq_fire)));
    assign deq_num      = CW'(rename_pkg::popcount(rename_pkg::POP_W'(deq_fire)));

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            count <= COUNT_INIT;
            for (int k = 0; k < IN_W; k++) begin
                enq_ptr[k] <= PW'(k);
            end
            for (int k = 0; k < OUT_W; k++) begin
                deq_ptr[k] <= PW'(k);
            end
        end else if (i_flush) begin
            count <= COUNT_INIT;
            for (int k = 0; k < IN_W; k++) begin
                enq_ptr[k] <= PW'(k);
            end
            for (int k = 0; k < OUT_W; k++) begin
                deq_ptr[k] <= PW'(k);
            end
        end else begin
            count <= count + enq_fire_num - deq_num;
            for (int k = 0; k < IN_W; k++) begin
                enq_ptr[k] <= advance(enq_ptr[k], enq_fire_num);
            end
            for (int k = 0; k < OUT_W; k++) begin
                deq_ptr[k] <= advance(deq_ptr[k], deq_num);
            end
        end
    end

    // storage reloaded while reset is held and on flush
    always_ff @(posedge clk) begin
        if (!i_arst_n || i_flush) begin
            for (int k = 0; k < DEPTH; k++) begin
                buffer[k] <= i_init_data[k];
            end
        end else begin
            for (int k = 0; k < IN_W; k++) begin
                if (enq_fire[k]) begin
                    buffer[enq_ptr[k]] <= i_enq_data[k];
                end
            end
        end
    end

    // oldest entries first
    for (genvar i = 0; i < OUT_W; i++) begin : g_out
        assign o_can_deq[i]  = count > CW'(i);
        assign o_deq_data[i] = buffer[deq_ptr[i]];
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        count <= CW'(DEPTH)
    );

    a_enq_prefix: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (enq_fire & (enq_fire + IN_W'(1))) == '0
    );

    a_deq_prefix: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (deq_fire & (deq_fire + OUT_W'(1))) == '0
    );

    a_deq_when_ready: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (i_deq_req & ~o_can_deq) == '0
    );

endmodule

//--- design/rename_map.sv
module rename_map (
    input  logic                                clk,
    input  logic                                i_arst_n,
    input  logic                                i_flush,
    // instruction queue heads
    input  logic [rename_pkg::RENAME_W-1:0]     i_iq_vld,
    input  rename_pkg::inst_t                   i_iq_inst [rename_pkg::RENAME_W],
    output logic [rename_pkg::RENAME_W-1:0]     o_iq_take,
    // free list heads
    input  logic [rename_pkg::RENAME_W-1:0]     i_fl_vld,
    input  rename_pkg::preg_t                   i_fl_tag [rename_pkg::RENAME_W],
    output logic [rename_pkg::RENAME_W-1:0]     o_fl_take,
    // to dispatch
    input  logic                                i_uop_rdy,
    output logic [rename_pkg::RENAME_W-1:0]     o_uop_vld,
    output logic [rename_pkg::RENAME_W-1:0]     o_uop_has_rd,
    output rename_pkg::preg_t                   o_uop_prd [rename_pkg::RENAME_W],
    output rename_pkg::preg_t                   o_uop_prs1 [rename_pkg::RENAME_W],
    output rename_pkg::preg_t                   o_uop_prs2 [rename_pkg::RENAME_W]
);

    rename_pkg::preg_t                   map_q [rename_pkg::NUM_AREG];
    logic [rename_pkg::SLOT_W-1:0]       fl_pos [rename_pkg::RENAME_W];
    logic [rename_pkg::RENAME_W-1:0]     fire;

    always_comb begin
        logic [rename_pkg::RENAME_W-1:0] vld;
        logic [rename_pkg::RENAME_W-1:0] want;
        logic [rename_pkg::SLOT_W-1:0]   pos;
        logic                            prev;
        rename_pkg::inst_t               ins;
        rename_pkg::preg_t               tag [rename_pkg::RENAME_W];
        vld  = '0;
        want = '0;
        prev = 1'b1;
        for (int k = 0; k < rename_pkg::RENAME_W; k++) begin
            ins = i_iq_inst[k];
            // next free tag after the older slots that took one
            pos = rename_pkg::SLOT_W'(rename_pkg::popcount(rename_pkg::POP_W'(want)));
            fl_pos[k] = pos;
            vld[k] = prev && i_iq_vld[k] && (!ins.has_rd || i_fl_vld[pos]);
            want[k] = vld[k] && ins.has_rd;
            prev = vld[k];
            tag[k] = ins.has_rd ? i_fl_tag[pos] : '0;

            o_uop_prs1[k] = map_q[ins.rs1];
            o_uop_prs2[k] = map_q[ins.rs2];
            // bypass from older slots in the group, youngest match last
            for (int j = 0; j < k; j++) begin
                if (i_iq_inst[j].has_rd && i_iq_inst[j].rd == ins.rs1) begin
                    o_uop_prs1[k] = tag[j];
                end
                if (i_iq_inst[j].has_rd && i_iq_inst[j].rd == ins.rs2) begin
                    o_uop_prs2[k] = tag[j];
                end
            end

            o_uop_prd[k]    = tag[k];
            o_uop_has_rd[k] = ins.has_rd;
        end
        o_uop_vld = vld;
    end

    assign fire      = o_uop_vld & {rename_pkg::RENAME_W{i_uop_rdy}};
    assign o_iq_take = fire;

    always_comb begin
        o_fl_take = '0;
        for (int k = 0; k < rename_pkg::RENAME_W; k++) begin
            if (fire[k] && i_iq_inst[k].has_rd) begin
                o_fl_take[fl_pos[k]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int a = 0; a < rename_pkg::NUM_AREG; a++) begin
                map_q[a] <= rename_pkg::preg_t'(a);
            end
        end else if (i_flush) begin
            for (int a = 0; a < rename_pkg::NUM_AREG; a++) begin
                map_q[a] <= rename_pkg::preg_t'(a);
            end
        end else begin
            // later slot overrides on the same rd
            for (int k = 0; k < rename_pkg::RENAME_W; k++) begin
                if (fire[k] && i_iq_inst[k].has_rd) begin
                    map_q[i_iq_inst[k].rd] <= o_uop_prd[k];
                end
            end
        end
    end

    a_fl_take_prefix: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (o_fl_take & (o_fl_take + rename_pkg::RENAME_W'(1))) == '0
    );

endmodule

//--- design/rename_pkg.sv
package rename_pkg;

    localparam int NUM_AREG   = 32;
    localparam int NUM_PREG   = 64;
    localparam int FREE_DEPTH = NUM_PREG - NUM_AREG;
    localparam int IQ_DEPTH   = 16;
    localparam int FETCH_W    = 4;
    localparam int RENAME_W   = 2;

    // index of a rename slot
    localparam int SLOT_W = $clog2(RENAME_W);

    // widest mask handed to popcount
    localparam int POP_W = 8;

    typedef logic [$clog2(NUM_AREG)-1:0] areg_t;
    typedef logic [$clog2(NUM_PREG)-1:0] preg_t;

    typedef struct packed {
        logic  has_rd;
        areg_t rd;
        areg_t rs1;
        areg_t rs2;
    } inst_t;

    // number of set bits, narrower masks are zero extended by the caller
    function automatic logic [POP_W-1:0] popcount(input logic [POP_W-1:0] v);
        logic [POP_W-1:0] n;
        n = '0;
        for (int k = 0; k < POP_W; k++) begin
            n = n + POP_W'(v[k]);
        end
        return n;
    endfunction

endpackage

//--- design/rename_top.sv
module rename_top (
    input  logic                                clk,
    input  logic                                i_arst_n,
    input  logic                                i_flush,
    // fetch
    output logic                                o_fetch_rdy,
    input  logic                                i_fetch_vld,
    input  logic [rename_pkg::FETCH_W-1:0]      i_fetch_mask,
    input  rename_pkg::inst_t                   i_fetch_inst [rename_pkg::FETCH_W],
    // dispatch
    output logic [rename_pkg::RENAME_W-1:0]     o_uop_vld,
    output logic [rename_pkg::RENAME_W-1:0]     o_uop_has_rd,
    output rename_pkg::preg_t                   o_uop_prd [rename_pkg::RENAME_W],
    output rename_pkg::preg_t                   o_uop_prs1 [rename_pkg::RENAME_W],
    output rename_pkg::preg_t                   o_uop_prs2 [rename_pkg::RENAME_W],
    input  logic                                i_uop_rdy,
    // commit
    input  logic [rename_pkg::RENAME_W-1:0]     i_commit_vld,
    input  rename_pkg::preg_t                   i_commit_preg [rename_pkg::RENAME_W]
);

    logic [rename_pkg::RENAME_W-1:0] iq_vld;
    logic [rename_pkg::RENAME_W-1:0] iq_take;
    rename_pkg::inst_t               iq_head [rename_pkg::RENAME_W];
    rename_pkg::inst_t               iq_init [rename_pkg::IQ_DEPTH];

    logic [rename_pkg::RENAME_W-1:0] fl_vld;
    logic [rename_pkg::RENAME_W-1:0] fl_take;
    logic                            fl_can_enq;
    rename_pkg::preg_t               fl_head [rename_pkg::RENAME_W];
    rename_pkg::preg_t               fl_init [rename_pkg::FREE_DEPTH];

    for (genvar k = 0; k < rename_pkg::IQ_DEPTH; k++) begin : g_iq_init
        assign iq_init[k] = '0;
    end

    // free list starts with the tags above the architectural range
    for (genvar k = 0; k < rename_pkg::FREE_DEPTH; k++) begin : g_fl_init
        assign fl_init[k] = rename_pkg::preg_t'(rename_pkg::NUM_AREG + k);
    end

    multiport_fifo #(
        .dtype     (rename_pkg::inst_t),
        .IN_W      (rename_pkg::FETCH_W),
        .OUT_W     (rename_pkg::RENAME_W),
        .DEPTH     (rename_pkg::IQ_DEPTH),
        .INIT_FULL (0)
    ) iq0 (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_flush     (i_flush),
        .o_can_enq   (o_fetch_rdy),
        .i_enq_vld   (i_fetch_vld),
        .i_enq_req   (i_fetch_mask),
        .i_enq_data  (i_fetch_inst),
        .o_can_deq   (iq_vld),
        .i_deq_req   (iq_take),
        .o_deq_data  (iq_head),
        .i_init_data (iq_init)
    );

    multiport_fifo #(
        .dtype     (rename_pkg::preg_t),
        .IN_W      (rename_pkg::RENAME_W),
        .OUT_W     (rename_pkg::RENAME_W),
        .DEPTH     (rename_pkg::FREE_DEPTH),
        .INIT_FULL (1)
    ) fl0 (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_flush     (i_flush),
        .o_can_enq   (fl_can_enq),
        .i_enq_vld   (|i_commit_vld),
        .i_enq_req   (i_commit_vld),
        .i_enq_data  (i_commit_preg),
        .o_can_deq   (fl_vld),
        .i_deq_req   (fl_take),
        .o_deq_data  (fl_head),
        .i_init_data (fl_init)
    );

    rename_map map0 (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_flush      (i_flush),
        .i_iq_vld     (iq_vld),
        .i_iq_inst    (iq_head),
        .o_iq_take    (iq_take),
        .i_fl_vld     (fl_vld),
        .i_fl_tag     (fl_head),
        .o_fl_take    (fl_take),
        .i_uop_rdy    (i_uop_rdy),
        .o_uop_vld    (o_uop_vld),
        .o_uop_has_rd (o_uop_has_rd),
        .o_uop_prd    (o_uop_prd),
        .o_uop_prs1   (o_uop_prs1),
        .o_uop_prs2   (o_uop_prs2)
    );

    // committed tags always find room in the free list
    a_commit_room: assert property (
        @(posedge clk) disable iff (!i_arst_n || i_flush)
        (|i_commit_vld) |-> fl_can_enq
    );

endmodule

//--- filelist.f
design/rename_pkg.sv
design/multiport_fifo.sv
design/rename_map.sv
design/rename_top.sv
tests/tb_clock.sv
tests/rename_tb.sv

//--- tests/rename_tb.sv
module rename_tb;

    localparam int WAIT_LIMIT = 40;

    typedef struct packed {
        logic        fvld;
        logic [3:0]  fmask;
        logic [63:0] finst;
        logic        rdy;
        logic [1:0]  cvld;
        logic [11:0] ctag;
        logic        flush;
    } row_t;

    logic                            clk;
    logic                            arst_n;
    logic                            flush;
    logic                            fetch_rdy;
    logic                            fetch_vld;
    logic [rename_pkg::FETCH_W-1:0]  fetch_mask;
    rename_pkg::inst_t               fetch_inst [rename_pkg::FETCH_W];
    logic [rename_pkg::RENAME_W-1:0] uop_vld;
    logic [rename_pkg::RENAME_W-1:0] uop_has_rd;
    rename_pkg::preg_t               uop_prd [rename_pkg::RENAME_W];
    rename_pkg::preg_t               uop_prs1 [rename_pkg::RENAME_W];
    rename_pkg::preg_t               uop_prs2 [rename_pkg::RENAME_W];
    logic                            uop_rdy;
    logic [rename_pkg::RENAME_W-1:0] commit_vld;
    rename_pkg::preg_t               commit_preg [rename_pkg::RENAME_W];

    // reference model of queue, free list and map
    rename_pkg::inst_t iq_m [$];
    rename_pkg::preg_t fl_m [$];
    rename_pkg::preg_t map_m [rename_pkg::NUM_AREG];

    row_t        rows [$];
    logic [31:0] lfsr_state;

    tb_clock #(.PERIOD(20), .RESET_CYCLES(4)) clk0 (.clk(clk), .o_arst_n(arst_n));

    rename_top dut0 (
        .clk           (clk),
        .i_arst_n      (arst_n),
        .i_flush       (flush),
        .o_fetch_rdy   (fetch_rdy),
        .i_fetch_vld   (fetch_vld),
        .i_fetch_mask  (fetch_mask),
        .i_fetch_inst  (fetch_inst),
        .o_uop_vld     (uop_vld),
        .o_uop_has_rd  (uop_has_rd),
        .o_uop_prd     (uop_prd),
        .o_uop_prs1    (uop_prs1),
        .o_uop_prs2    (uop_prs2),
        .i_uop_rdy     (uop_rdy),
        .i_commit_vld  (commit_vld),
        .i_commit_preg (commit_preg)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("FAILED %s expected %0h actual %0h", name, exp, act);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic rename_pkg::inst_t make_inst(
        input logic has_rd, input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2
    );
        return {has_rd, rd, rs1, rs2};
    endfunction

    // four random instructions, slot 0 in the low bits
    task automatic random_group(input logic need_rd, output logic [63:0] grp);
        logic [31:0] b;
        for (int k = 0; k < rename_pkg::FETCH_W; k++) begin
            if (need_rd) begin
                take_bits(15, b);
                grp[k*16 +: 16] = {1'b1, b[14:0]};
            end else begin
                take_bits(16, b);
                grp[k*16 +: 16] = b[15:0];
            end
        end
    endtask

    function automatic row_t make_row(
        input logic fvld, input logic [3:0] fmask, input logic [63:0] finst, input logic rdy,
        input logic [1:0] cvld, input logic [11:0] ctag, input logic fl
    );
        return {fvld, fmask, finst, rdy, cvld, ctag, fl};
    endfunction

    function automatic row_t idle_row(input logic rdy);
        return make_row(1'b0, 4'h0, 64'h0, rdy, 2'b00, 12'h0, 1'b0);
    endfunction

    task automatic model_reset();
        iq_m.delete();
        fl_m.delete();
        for (int t = 0; t < rename_pkg::FREE_DEPTH; t++) begin
            fl_m.push_back(rename_pkg::preg_t'(rename_pkg::NUM_AREG + t));
        end
        for (int a = 0; a < rename_pkg::NUM_AREG; a++) begin
            map_m[a] = rename_pkg::preg_t'(a);
        end
    endtask

    task automatic drive_row(input row_t r);
        fetch_vld  <= r.fvld;
        fetch_mask <= r.fmask;
        uop_rdy    <= r.rdy;
        commit_vld <= r.cvld;
        flush      <= r.flush;
        for (int k = 0; k < rename_pkg::FETCH_W; k++) begin
            fetch_inst[k] <= r.finst[k*16 +: 16];
        end
        for (int k = 0; k < rename_pkg::RENAME_W; k++) begin
            commit_preg[k] <= r.ctag[k*6 +: 6];
        end
    endtask

    // compare outputs with the model, then step the model through the coming edge
    task automatic check_and_advance(input row_t r, output logic accepted);
        logic [rename_pkg::RENAME_W-1:0] vld;
        rename_pkg::preg_t               tag [rename_pkg::RENAME_W];
        rename_pkg::inst_t               ins [rename_pkg::RENAME_W];
        rename_pkg::preg_t               src1;
        rename_pkg::preg_t               src2;
        logic                            prev;
        logic                            room;
        int                              used;
        int                              nfetch;
        vld = '0;
        prev = 1'b1;
        used = 0;
        nfetch = 0;
        for (int k = 0; k < rename_pkg::RENAME_W; k++) begin
            ins[k] = '0;
            tag[k] = '0;
            if (k < iq_m.size()) begin
                ins[k] = iq_m[k];
                vld[k] = prev && (!ins[k].has_rd || used < fl_m.size());
            end
            if (vld[k] && ins[k].has_rd) begin
                tag[k] = fl_m[used];
                used++;
            end
            prev = vld[k];
        end
        expect_equal("o_uop_vld", 32'(vld), 32'(uop_vld));
        for (int k = 0; k < rename_pkg::RENAME_W; k++) begin
            if (vld[k]) begin
                src1 = map_m[ins[k].rs1];
                src2 = map_m[ins[k].rs2];
                for (int j = 0; j < k; j++) begin
                    if (ins[j].has_rd && ins[j].rd == ins[k].rs1) begin
                        src1 = tag[j];
                    end
                    if (ins[j].has_rd && ins[j].rd == ins[k].rs2) begin
                        src2 = tag[j];
                    end
                end
                expect_equal($sformatf("o_uop_has_rd[%0d]", k), 32'(ins[k].has_rd),
                             32'(uop_has_rd[k]));
                if (ins[k].has_rd) begin
                    expect_equal($sformatf("o_uop_prd[%0d]", k), 32'(tag[k]), 32'(uop_prd[k]));
                end
                expect_equal($sformatf("o_uop_prs1[%0d]", k), 32'(src1), 32'(uop_prs1[k]));
                expect_equal($sformatf("o_uop_prs2[%0d]", k), 32'(src2), 32'(uop_prs2[k]));
            end
        end
        for (int k = 0; k < rename_pkg::FETCH_W; k++) begin
            if (r.fmask[k]) begin
                nfetch++;
            end
        end
        room = nfetch <= rename_pkg::IQ_DEPTH - iq_m.size();
        expect_equal("o_fetch_rdy", 32'(room), 32'(fetch_rdy));
        accepted = r.fvld && room && !r.flush;
        if (r.flush) begin
            model_reset();
        end else begin
            for (int k = 0; k < rename_pkg::RENAME_W; k++) begin
                if (vld[k] && r.rdy) begin
                    void'(iq_m.pop_front());
                    if (ins[k].has_rd) begin
                        map_m[ins[k].rd] = tag[k];
                        void'(fl_m.pop_front());
                    end
                end
            end
            for (int k = 0; k < rename_pkg::RENAME_W; k++) begin
                if (r.cvld[k]) begin
                    fl_m.push_back(r.ctag[k*6 +: 6]);
                end
            end
            for (int k = 0; k < rename_pkg::FETCH_W; k++) begin
                if (accepted && r.fmask[k]) begin
                    iq_m.push_back(r.finst[k*16 +: 16]);
                end
            end
        end
    endtask

    task automatic run_cycle(input row_t r, output logic accepted);
        @(posedge clk);
        drive_row(r);
        @(negedge clk);
        check_and_advance(r, accepted);
    endtask

    task automatic apply_row(input row_t r);
        row_t cur;
        logic accepted;
        int   n;
        cur = r;
        n = 0;
        run_cycle(cur, accepted);
        // fetch holds its group, commit and flush happen once
        cur.cvld = 2'b00;
        cur.flush = 1'b0;
        while (cur.fvld && !accepted) begin
            if (n == WAIT_LIMIT) begin
                stop_on_error("fetch group was never accepted by the instruction queue");
            end
            run_cycle(cur, accepted);
            n++;
        end
    endtask

    task automatic wait_reset_done();
        int n;
        n = 0;
        while (arst_n !== 1'b1) begin
            if (n == WAIT_LIMIT) begin
                stop_on_error("reset was never released");
            end
            @(negedge clk);
            if (arst_n !== 1'b1) begin
                expect_equal("o_uop_vld", 32'h0, 32'(uop_vld));
            end
            n++;
        end
    endtask

    task automatic wait_fetch_ready();
        int n;
        n = 0;
        while (fetch_rdy !== 1'b1) begin
            if (n == WAIT_LIMIT) begin
                stop_on_error("o_fetch_rdy never rose after reset");
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic drain_queue();
        logic accepted;
        int   n;
        n = 0;
        while (uop_vld !== '0) begin
            if (n == WAIT_LIMIT) begin
                stop_on_error("renamer never emptied the instruction queue");
            end
            run_cycle(idle_row(1'b1), accepted);
            n++;
        end
    endtask

    initial begin
        logic [63:0] grp;
        logic [31:0] b;
        lfsr_state = 32'h9fc0;
        flush = 1'b0;
        fetch_vld = 1'b0;
        fetch_mask = '0;
        uop_rdy = 1'b0;
        commit_vld = '0;
        for (int k = 0; k < rename_pkg::FETCH_W; k++) begin
            fetch_inst[k] = '0;
        end
        for (int k = 0; k < rename_pkg::RENAME_W; k++) begin
            commit_preg[k] = '0;
        end
        model_reset();

        // single instruction sees the identity map
        rows.push_back(make_row(1'b1, 4'b0001, 64'(make_inst(1'b1, 5'd5, 5'd3, 5'd7)),
                                1'b0, 2'b00, 12'h0, 1'b0));
        rows.push_back(idle_row(1'b0));
        rows.push_back(idle_row(1'b1));
        // bypass inside the group, younger write to r4 wins
        rows.push_back(make_row(1'b1, 4'b0111,
                                {16'h0, make_inst(1'b0, 5'd0, 5'd4, 5'd4),
                                 make_inst(1'b1, 5'd4, 5'd4, 5'd3),
                                 make_inst(1'b1, 5'd4, 5'd1, 5'd2)},
                                1'b1, 2'b00, 12'h0, 1'b0));
        repeat (3) rows.push_back(idle_row(1'b1));
        // fill the queue while dispatch is stalled
        repeat (4) begin
            random_group(1'b0, grp);
            rows.push_back(make_row(1'b1, 4'hf, grp, 1'b0, 2'b00, 12'h0, 1'b0));
        end
        repeat (2) rows.push_back(make_row(1'b0, 4'hf, 64'h0, 1'b0, 2'b00, 12'h0, 1'b0));
        random_group(1'b0, grp);
        rows.push_back(make_row(1'b1, 4'hf, grp, 1'b1, 2'b00, 12'h0, 1'b0));
        repeat (10) begin
            take_bits(1, b);
            rows.push_back(idle_row(b[0]));
        end
        // flush with work still queued
        rows.push_back(make_row(1'b0, 4'h0, 64'h0, 1'b0, 2'b00, 12'h0, 1'b1));
        rows.push_back(make_row(1'b1, 4'b0011,
                                {32'h0, make_inst(1'b1, 5'd2, 5'd1, 5'd0),
                                 make_inst(1'b1, 5'd1, 5'd4, 5'd9)},
                                1'b1, 2'b00, 12'h0, 1'b0));
        // 34 destinations against 32 free tags
        repeat (8) begin
            random_group(1'b1, grp);
            rows.push_back(make_row(1'b1, 4'hf, grp, 1'b1, 2'b00, 12'h0, 1'b0));
        end
        // tags run out, last two uops stall until commit
        repeat (8) rows.push_back(idle_row(1'b1));
        rows.push_back(make_row(1'b0, 4'h0, 64'h0, 1'b1, 2'b11, {6'd40, 6'd7}, 1'b0));
        repeat (3) rows.push_back(idle_row(1'b1));

        wait_reset_done();
        wait_fetch_ready();
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
        end
        drain_queue();
        apply_row(make_row(1'b0, 4'h0, 64'h0, 1'b0, 2'b00, 12'h0, 1'b1));
        apply_row(idle_row(1'b0));

        $display("** PASS **");
        $finish;
    end

endmodule

//--- tests/tb_clock.sv
module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic o_arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // released on a rising edge like the other inputs
    initial begin
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        o_arst_n <= 1'b1;
    end

endmodule
